// File: mem_types_pkg.sv
// shared bus types for the two-port word memory
// word, byte address, write strobe and request payload structs
// byte-merge helper for strobed writes

`default_nettype none

package mem_types_pkg;

    localparam int WORD_BITS      = 32;
    localparam int BYTES_PER_WORD = WORD_BITS / 8;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [31:0]               address_t;

    // one enable per byte, all zero for a read
    typedef logic [BYTES_PER_WORD-1:0] strobe_t;

    // instruction fetch carries only the address
    typedef struct packed {
        address_t address;
    } fetch_req_t;

    typedef struct packed {
        address_t address;
        word_t    wdata;
        strobe_t  wstrobe;
    } data_req_t;

    // new byte where the strobe bit is set, old byte elsewhere
    function automatic word_t merge_bytes(
        input word_t   old_word,
        input word_t   new_word,
        input strobe_t strobe
    );
        word_t result;
        result = old_word;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (strobe[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: mem_config_pkg.sv
// memory geometry and initial image for the word memory

`default_nettype none

package mem_config_pkg;

    localparam int SIZE_WORDS = 64;

    // word index sits above the two byte-offset bits
    localparam int LOCAL_ADDRESS_WIDTH = $clog2(SIZE_WORDS);
    localparam int WORD_OFFSET         = 2;

    localparam string INIT_FILE = "mem_init.hex";

    typedef logic [LOCAL_ADDRESS_WIDTH-1:0] local_address_t;

endpackage

`default_nettype wire

// File: bus_request_stage.sv
// four-phase request capture for one port
// holds the payload and valid until the core accepts the access,
// then waits for req to drop and pulses release_pulse

`timescale 1ns/1ps
`default_nettype none

module bus_request_stage
    import mem_types_pkg::*;
#(
    parameter type payload_t = word_t
) (
    input  logic     dbus,
    input  logic     rst,
    input  logic     req,
    input  payload_t payload_in,
    output logic     valid,
    output payload_t payload,
    input  logic     fire,
    output logic     release_pulse
);

    typedef enum logic [1:0] {
        IDLE,
        PENDING,
        DONE
    } state_t;

    state_t state;

    always_ff @(posedge dbus) begin
        if (rst) begin
            state         <= IDLE;
            valid         <= 1'b0;
            release_pulse <= 1'b0;
        end else begin
            release_pulse <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= PENDING;
                        valid <= 1'b1;
                    end
                end
                PENDING: begin
                    // core accepted, wait for the master to drop req
                    if (fire) begin
                        state <= DONE;
                        valid <= 1'b0;
                    end
                end
                DONE: begin
                    if (!req) begin
                        state         <= IDLE;
                        release_pulse <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                    valid <= 1'b0;
                end
            endcase
        end
    end

    // payload captured once per handshake
    always_ff @(posedge dbus) begin
        if (state == IDLE && req) begin
            payload <= payload_in;
        end
    end

    no_valid_when_done: assert property (@(posedge dbus) disable iff (rst)
        state == DONE |-> !valid);

    payload_held: assert property (@(posedge dbus) disable iff (rst)
        valid ##1 valid |-> $stable(payload));

endmodule

`default_nettype wire

// File: memory_core.sv
// shared word array for the fetch and data ports
// per-port read register with address tag, ready/fire generation,
// strobed writes on the data port with tag invalidation

`timescale 1ns/1ps
`default_nettype none

module memory_core
    import mem_types_pkg::*;
    import mem_config_pkg::*;
(
    input  logic       dbus,
    input  logic       rst,
    input  logic       fetch_valid,
    input  fetch_req_t fetch_payload,
    output logic       fetch_fire,
    output word_t      fetch_rdata,
    input  logic       data_valid,
    input  data_req_t  data_payload,
    output logic       data_fire,
    output word_t      data_rdata
);

    // spare top bit, so the all-ones value never matches a real word
    typedef logic [LOCAL_ADDRESS_WIDTH:0] tag_t;

    word_t mem [SIZE_WORDS];

    initial begin
        $readmemh(INIT_FILE, mem);
    end

    local_address_t fetch_local;
    tag_t           fetch_tag;
    logic           fetch_ready;

    local_address_t data_local;
    tag_t           data_tag;
    logic           data_ready;
    logic           data_is_write;
    logic           data_write;

    // upper address bits ignored, accesses wrap
    assign fetch_local = fetch_payload.address[WORD_OFFSET +: LOCAL_ADDRESS_WIDTH];
    assign data_local  = data_payload.address[WORD_OFFSET +: LOCAL_ADDRESS_WIDTH];

    assign data_is_write = data_payload.wstrobe != '0;
    assign data_write    = data_fire && data_is_write;

    // a read is ready once the read register holds the requested word
    assign fetch_ready = !fetch_valid || fetch_tag == {1'b0, fetch_local};
    assign data_ready  = !data_valid || data_is_write || data_tag == {1'b0, data_local};

    assign fetch_fire = fetch_valid && fetch_ready;
    assign data_fire  = data_valid && data_ready;

    always_ff @(posedge dbus) begin
        if (fetch_valid) begin
            fetch_rdata <= mem[fetch_local];
        end
    end

    always_ff @(posedge dbus) begin
        if (data_valid) begin
            data_rdata <= mem[data_local];
        end
    end

    always_ff @(posedge dbus) begin
        if (data_write) begin
            mem[data_local] <= merge_bytes(mem[data_local], data_payload.wdata,
                                           data_payload.wstrobe);
        end
    end

    // any write drops both tags, next read of any word reloads
    always_ff @(posedge dbus) begin
        if (rst || data_write) begin
            fetch_tag <= '1;
        end else if (fetch_valid) begin
            fetch_tag <= {1'b0, fetch_local};
        end
    end

    always_ff @(posedge dbus) begin
        if (rst || data_write) begin
            data_tag <= '1;
        end else if (data_valid) begin
            data_tag <= {1'b0, data_local};
        end
    end

    fire_needs_valid: assert property (@(posedge dbus) disable iff (rst)
        (fetch_fire |-> fetch_valid) and (data_fire |-> data_valid));

endmodule

`default_nettype wire

// File: bus_response_stage.sv
// response side of one port
// holds the read word and drives the four-phase ack

`timescale 1ns/1ps
`default_nettype none

module bus_response_stage
    import mem_types_pkg::*;
(
    input  logic  dbus,
    input  logic  rst,
    input  logic  fire,
    input  logic  release_pulse,
    input  word_t rdata_in,
    output logic  ack,
    output word_t rdata
);

    // ack up one cycle after the core accepts, down after release
    always_ff @(posedge dbus) begin
        if (rst) begin
            ack <= 1'b0;
        end else if (fire) begin
            ack <= 1'b1;
        end else if (release_pulse) begin
            ack <= 1'b0;
        end
    end

    // read word stays put until the next access
    always_ff @(posedge dbus) begin
        if (fire) begin
            rdata <= rdata_in;
        end
    end

    no_fire_during_ack: assert property (@(posedge dbus) disable iff (rst)
        fire |-> !ack);

    release_only_with_ack: assert property (@(posedge dbus) disable iff (rst)
        release_pulse |-> ack);

endmodule

`default_nettype wire

// File: mem_subsys_top.sv
// two-port word memory subsystem
// fetch and data pipelines: request stage, shared core, response stage

`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
    import mem_types_pkg::*;
(
    input  logic     dbus,
    input  logic     rst,

    input  logic     fetch_req,
    input  address_t fetch_address,
    output logic     fetch_ack,
    output word_t    fetch_rdata,

    input  logic     data_req,
    input  address_t data_address,
    input  word_t    data_wdata,
    input  strobe_t  data_wstrobe,
    output logic     data_ack,
    output word_t    data_rdata
);

    fetch_req_t fetch_in;
    fetch_req_t fetch_payload;
    logic       fetch_valid;
    logic       fetch_fire;
    logic       fetch_release;
    word_t      fetch_core_rdata;

    data_req_t  data_in;
    data_req_t  data_payload;
    logic       data_valid;
    logic       data_fire;
    logic       data_release;
    word_t      data_core_rdata;

    assign fetch_in = '{address: fetch_address};
    assign data_in  = '{address: data_address, wdata: data_wdata, wstrobe: data_wstrobe};

    bus_request_stage #(.payload_t(fetch_req_t)) fetch_request (
        .dbus(dbus), .rst(rst), .req(fetch_req), .payload_in(fetch_in),
        .valid(fetch_valid), .payload(fetch_payload),
        .fire(fetch_fire), .release_pulse(fetch_release)
    );

    bus_request_stage #(.payload_t(data_req_t)) data_request (
        .dbus(dbus), .rst(rst), .req(data_req), .payload_in(data_in),
        .valid(data_valid), .payload(data_payload),
        .fire(data_fire), .release_pulse(data_release)
    );

    memory_core core (
        .dbus(dbus), .rst(rst),
        .fetch_valid(fetch_valid), .fetch_payload(fetch_payload),
        .fetch_fire(fetch_fire), .fetch_rdata(fetch_core_rdata),
        .data_valid(data_valid), .data_payload(data_payload),
        .data_fire(data_fire), .data_rdata(data_core_rdata)
    );

    bus_response_stage fetch_response (
        .dbus(dbus), .rst(rst), .fire(fetch_fire), .release_pulse(fetch_release),
        .rdata_in(fetch_core_rdata), .ack(fetch_ack), .rdata(fetch_rdata)
    );

    bus_response_stage data_response (
        .dbus(dbus), .rst(rst), .fire(data_fire), .release_pulse(data_release),
        .rdata_in(data_core_rdata), .ack(data_ack), .rdata(data_rdata)
    );

endmodule

`default_nettype wire

// File: tb_mem_subsys.sv
// testbench for the two-port word memory subsystem
// clock and reset, LFSR stimulus, reference memory model,
// fetch and data four-phase masters, ack checker

`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
    import mem_types_pkg::*;
    import mem_config_pkg::*;
;

    localparam int          TIMEOUT_CYCLES = 20;
    localparam logic [31:0] LFSR_TAPS      = 32'h8020_0003;

    logic     dbus;
    logic     rst;
    logic     fetch_req;
    address_t fetch_address;
    logic     fetch_ack;
    word_t    fetch_rdata;
    logic     data_req;
    address_t data_address;
    word_t    data_wdata;
    strobe_t  data_wstrobe;
    logic     data_ack;
    word_t    data_rdata;

    // reference memory, updated when a data write is acked
    word_t       model [SIZE_WORDS];
    logic [31:0] fetch_lfsr;
    logic [31:0] data_lfsr;

    logic prev_fetch_ack;
    logic prev_fetch_req;
    logic prev_data_ack;
    logic prev_data_req;

    mem_subsys_top uut (
        .dbus(dbus), .rst(rst),
        .fetch_req(fetch_req), .fetch_address(fetch_address),
        .fetch_ack(fetch_ack), .fetch_rdata(fetch_rdata),
        .data_req(data_req), .data_address(data_address),
        .data_wdata(data_wdata), .data_wstrobe(data_wstrobe),
        .data_ack(data_ack), .data_rdata(data_rdata)
    );

    initial begin
        dbus = 1'b0;
        forever #20 dbus = ~dbus;
    end

    task automatic abort_run(input string what);
        $display("%0t: %s", $time, what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
        $display("Test FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(inout logic [31:0] state, input int count,
                             output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits  = {bits[30:0], state[0]};
            state = lfsr_step(state);
        end
    endtask

    // word held by the model after the access, unchanged for a read
    function automatic word_t reference_access(input address_t addr, input word_t wdata,
                                               input strobe_t strobe);
        word_t mask;
        word_t old_word;
        old_word = model[addr[2 +: LOCAL_ADDRESS_WIDTH]];
        for (int b = 0; b < 4; b++) begin
            mask[8*b +: 8] = {8{strobe[b]}};
        end
        return (old_word & ~mask) | (wdata & mask);
    endfunction

    task automatic idle_cycles(input logic [1:0] n);
        repeat (n) @(negedge dbus);
    endtask

    task automatic fetch_access(input address_t addr);
        int waited;
        @(negedge dbus);
        fetch_address = addr;
        fetch_req     = 1'b1;
        waited        = 0;
        while (!fetch_ack) begin
            @(negedge dbus);
            waited++;
            if (waited > TIMEOUT_CYCLES) abort_run("fetch_ack never rose after fetch_req");
        end
        fetch_req = 1'b0;
        waited    = 0;
        while (fetch_ack) begin
            @(negedge dbus);
            waited++;
            if (waited > TIMEOUT_CYCLES) abort_run("fetch_ack stayed high after fetch_req fell");
        end
    endtask

    task automatic data_access(input address_t addr, input word_t wdata, input strobe_t strobe);
        int waited;
        @(negedge dbus);
        data_address = addr;
        data_wdata   = wdata;
        data_wstrobe = strobe;
        data_req     = 1'b1;
        waited       = 0;
        while (!data_ack) begin
            @(negedge dbus);
            waited++;
            if (waited > TIMEOUT_CYCLES) abort_run("data_ack never rose after data_req");
        end
        data_req = 1'b0;
        waited   = 0;
        while (data_ack) begin
            @(negedge dbus);
            waited++;
            if (waited > TIMEOUT_CYCLES) abort_run("data_ack stayed high after data_req fell");
        end
    endtask

    // fetches stay in the half that the data port does not write this round
    task automatic random_fetches(input int round, input int count);
        logic [31:0] bits;
        address_t    addr;
        for (int n = 0; n < count; n++) begin
            take_bits(fetch_lfsr, 11, bits);
            addr = {20'h0, bits[10:7], ~round[0], bits[6:2], bits[1:0]};
            fetch_access(addr);
            take_bits(fetch_lfsr, 2, bits);
            idle_cycles(bits[1:0]);
        end
    endtask

    task automatic random_data(input int round, input int count);
        logic [31:0] bits;
        logic [31:0] wdata;
        address_t    addr;
        strobe_t     strobe;
        for (int n = 0; n < count; n++) begin
            take_bits(data_lfsr, 13, bits);
            take_bits(data_lfsr, 32, wdata);
            if (bits[12]) begin
                strobe = (bits[11:8] == 4'h0) ? 4'hF : bits[11:8];
                addr   = {24'h0, round[0], bits[6:2], 2'b00};
            end else begin
                strobe = 4'h0;
                addr   = {24'h0, bits[7:2], bits[1:0]};
            end
            data_access(addr, wdata, strobe);
            take_bits(data_lfsr, 2, bits);
            idle_cycles(bits[1:0]);
        end
    endtask

    // ack rises seen at the clock edge, values sampled before the update
    initial begin
        prev_fetch_ack = 1'b0;
        prev_fetch_req = 1'b0;
        prev_data_ack  = 1'b0;
        prev_data_req  = 1'b0;
        forever begin
            @(posedge dbus);
            if (!rst && fetch_ack && !prev_fetch_ack) begin
                assert (prev_fetch_req) else abort_run("fetch_ack rose without fetch_req");
                assert (fetch_rdata == reference_access(fetch_address, '0, '0))
                    else report_mismatch("fetch_rdata", fetch_rdata,
                                         reference_access(fetch_address, '0, '0));
            end
            if (!rst && data_ack && !prev_data_ack) begin
                assert (prev_data_req) else abort_run("data_ack rose without data_req");
                if (data_wstrobe != 4'h0) begin
                    model[data_address[2 +: LOCAL_ADDRESS_WIDTH]] =
                        reference_access(data_address, data_wdata, data_wstrobe);
                end else begin
                    assert (data_rdata == reference_access(data_address, '0, '0))
                        else report_mismatch("data_rdata", data_rdata,
                                             reference_access(data_address, '0, '0));
                end
            end
            prev_fetch_ack = fetch_ack;
            prev_fetch_req = fetch_req;
            prev_data_ack  = data_ack;
            prev_data_req  = data_req;
        end
    end

    initial begin
        rst           = 1'b1;
        fetch_req     = 1'b0;
        fetch_address = '0;
        data_req      = 1'b0;
        data_address  = '0;
        data_wdata    = '0;
        data_wstrobe  = '0;
        fetch_lfsr    = 32'd42;
        data_lfsr     = 32'd42;
        $readmemh(INIT_FILE, model);
        repeat (2) @(posedge dbus);
        @(negedge dbus);
        rst = 1'b0;

        // quiet bus after reset
        repeat (5) begin
            @(posedge dbus);
            assert (!fetch_ack && !data_ack) else abort_run("ack high with no request");
        end

        // whole image, repeated and aliased fetches
        for (int w = 0; w < SIZE_WORDS; w++) begin
            fetch_access(w * 4);
            fetch_access(w * 4);
            fetch_access(32'h100 + w * 4 + (w % 4));
        end

        // strobe patterns, each write read back on the data port
        for (int k = 0; k < 8; k++) begin
            strobe_t patterns [8];
            patterns = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'h5, 4'hF};
            data_access(32'h20 + k * 4, 32'hDEAD_0000 + k * 32'h0101_0101, patterns[k]);
            data_access(32'h20 + k * 4, '0, '0);
        end

        // fetched word rewritten through the data port
        for (int w = 0; w < 4; w++) begin
            fetch_access(w * 4);
            data_access(w * 4, 32'hC0DE_0000 + w, 4'hF);
            fetch_access(w * 4);
        end

        for (int round = 0; round < 4; round++) begin
            fork
                random_fetches(round, 20);
                random_data(round, 20);
            join
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_init.hex
// one 32-bit word per line, word address 0 to 63
8000ff00
8101fe04
8202fd08
8303fc0c
8404fb10
8505fa14
8606f918
8707f81c
8808f720
8909f624
8a0af528
8b0bf42c
8c0cf330
8d0df234
8e0ef138
8f0ff03c
9010ef40
9111ee44
9212ed48
9313ec4c
9414eb50
9515ea54
9616e958
9717e85c
9818e760
9919e664
9a1ae568
9b1be46c
9c1ce370
9d1de274
9e1ee178
9f1fe07c
a020df80
a121de84
a222dd88
a323dc8c
a424db90
a525da94
a626d998
a727d89c
a828d7a0
a929d6a4
aa2ad5a8
ab2bd4ac
ac2cd3b0
ad2dd2b4
ae2ed1b8
af2fd0bc
b030cfc0
b131cec4
b232cdc8
b333cccc
b434cbd0
b535cad4
b636c9d8
b737c8dc
b838c7e0
b939c6e4
ba3ac5e8
bb3bc4ec
bc3cc3f0
bd3dc2f4
be3ec1f8
bf3fc0fc

// File: build.f
mem_types_pkg.sv
mem_config_pkg.sv
bus_request_stage.sv
memory_core.sv
bus_response_stage.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_mem_subsys \
    -o sim_tb_mem_subsys

# the log decides the result, a fatal stop leaves no pass line
./obj_dir/sim_tb_mem_subsys 2>&1 | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
